//--- design/fds_pkg.sv
// fds mapper shared package: register map, bus structs and memory mapping constants
package fds_pkg;

	// timer registers
	localparam logic [15:0] REG_TIMER_LO     = 16'h4020;
	localparam logic [15:0] REG_TIMER_HI     = 16'h4021;
	localparam logic [15:0] REG_TIMER_CTRL   = 16'h4022;
	// drive control and side select
	localparam logic [15:0] REG_DISK_CTRL    = 16'h4025;
	localparam logic [15:0] REG_DISK_SIDE    = 16'h4027;
	// status reads
	localparam logic [15:0] REG_IRQ_STATUS   = 16'h4030;
	localparam logic [15:0] REG_DRIVE_STATUS = 16'h4032;
	localparam logic [15:0] REG_POWER_STATUS = 16'h4033;
	localparam logic [15:0] REG_SAVE_FLAG    = 16'h4208;
	// bios addresses that mark a disk byte transfer
	localparam logic [15:0] REG_READ_LO      = 16'hF4D0;
	localparam logic [15:0] REG_READ_HI      = 16'hF4D1;
	localparam logic [15:0] REG_WRITE_LO     = 16'hF4CD;
	localparam logic [15:0] REG_WRITE_HI     = 16'hF4CE;

	// image layout, header then fixed size sides
	localparam int unsigned SIDE_LEN  = 65500;
	localparam int unsigned SIDE_BASE = 16;

	// external memory widths
	localparam int PRG_ADDR_W = 22;
	localparam int CHR_ADDR_W = 22;
	localparam logic [2:0] CHR_RAM_BASE = 3'b100;

	// one cpu cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rd;
		logic        wr;
	} cpu_bus_t;

	typedef struct packed {
		logic [15:0] timer_latch;
		logic        timer_en;
		logic        timer_repeat;
		logic        disk_reset;
		logic        write_en;
		logic        vertical;
		logic [1:0]  side_auto;
	} ctrl_regs_t;

	// second step of each two-read sequence
	typedef struct packed {
		logic read_active;
		logic write_active;
	} seq_t;

	typedef struct packed {
		logic [17:0] rom_offset;
		logic        disk_end;
	} disk_info_t;

	// offset readback ports, write pair only while writing is enabled
	function automatic logic is_offset_lo(logic [15:0] addr, logic write_en);
		return (addr == REG_READ_LO) || (write_en && addr == REG_WRITE_LO);
	endfunction

	function automatic logic is_offset_hi(logic [15:0] addr, logic write_en);
		return (addr == REG_READ_HI) || (write_en && addr == REG_WRITE_HI);
	endfunction

endpackage

//--- design/fds_ctrl.sv
// fds register control: cpu register writes, disk transfer sequence detection, save flag
`timescale 1ns/1ps

module fds_ctrl import fds_pkg::*; (
	input  logic       clk20,
	input  logic       reset,
	input  logic       ce,
	input  cpu_bus_t   cpu,
	output ctrl_regs_t regs,
	output seq_t       seq,
	output logic       saved
);

	// 0 idle, 1 low address seen, 2 transfer cycle
	logic [1:0] rd_state;
	logic [1:0] wr_state;
	logic       wr_cycle;
	logic       rd_cycle;

	assign wr_cycle = ce & cpu.wr;
	assign rd_cycle = ce & cpu.rd;

	// shared step rule for both detectors
	function automatic logic [1:0] seq_next(logic [1:0] state, logic lo_hit, logic hi_hit);
		if (lo_hit)
			return 2'd1;
		else if (hi_hit && state == 2'd1)
			return 2'd2;
		else
			return 2'd0;
	endfunction

	// timer latch bytes
	always_ff @(posedge clk20) begin
		if (wr_cycle && cpu.addr == REG_TIMER_LO)
			regs.timer_latch[7:0] <= cpu.data;
		if (wr_cycle && cpu.addr == REG_TIMER_HI)
			regs.timer_latch[15:8] <= cpu.data;
	end

	// control bits
	always_ff @(posedge clk20) begin
		if (reset) begin
			regs.timer_en     <= 1'b0;
			regs.timer_repeat <= 1'b0;
			regs.disk_reset   <= 1'b0;
			regs.write_en     <= 1'b0;
			regs.vertical     <= 1'b0;
			regs.side_auto    <= 2'd0;
		end else if (wr_cycle) begin
			case (cpu.addr)
				REG_TIMER_CTRL: begin
					regs.timer_repeat <= cpu.data[0];
					regs.timer_en     <= cpu.data[1];
				end
				REG_DISK_CTRL: begin
					// write enable and mirroring are active low
					regs.disk_reset <= cpu.data[1];
					regs.write_en   <= ~cpu.data[2];
					regs.vertical   <= ~cpu.data[3];
				end
				REG_DISK_SIDE:
					regs.side_auto <= cpu.data[1:0];
				default: ;
			endcase
		end
	end

	// two-read detectors, one step per ce
	always_ff @(posedge clk20) begin
		if (reset) begin
			rd_state <= 2'd0;
			wr_state <= 2'd0;
		end else if (ce) begin
			rd_state <= seq_next(rd_state, rd_cycle && cpu.addr == REG_READ_LO,
				rd_cycle && cpu.addr == REG_READ_HI);
			// write side needs write enable to start
			wr_state <= seq_next(wr_state,
				rd_cycle && regs.write_en && cpu.addr == REG_WRITE_LO,
				rd_cycle && cpu.addr == REG_WRITE_HI);
		end
	end

	assign seq.read_active  = (rd_state == 2'd2);
	assign seq.write_active = (wr_state == 2'd2);

	// sticky once anything was written to disk
	always_ff @(posedge clk20) begin
		if (reset)
			saved <= 1'b0;
		else if (ce && seq.write_active)
			saved <= 1'b1;
	end

endmodule

//--- design/fds_timer.sv
// fds timer: 16-bit reloading down-counter driving the timer interrupt
`timescale 1ns/1ps

module fds_timer import fds_pkg::*; (
	input  logic       clk20,
	input  logic       reset,
	input  logic       ce,
	input  cpu_bus_t   cpu,
	input  ctrl_regs_t regs,
	output logic       irq
);

	logic [15:0] count;
	logic        trip;
	logic        ctrl_write;
	logic        status_read;

	// trips on the strobe that would take the count from 1 to 0
	assign trip        = regs.timer_en && count == 16'd1;
	assign ctrl_write  = cpu.wr && cpu.addr == REG_TIMER_CTRL;
	assign status_read = cpu.rd && cpu.addr == REG_IRQ_STATUS;

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= 16'd0;
		end else if (ce) begin
			// control write or repeat trip reloads from the latch
			if (ctrl_write || (trip && regs.timer_repeat))
				count <= regs.timer_latch;
			else if (regs.timer_en && count != 16'd0)
				count <= count - 16'd1;
		end
	end

	// status read wins over a trip in the same cycle
	always_ff @(posedge clk20) begin
		if (reset)
			irq <= 1'b0;
		else if (ce) begin
			if (status_read)
				irq <= 1'b0;
			else if (trip)
				irq <= 1'b1;
		end
	end

endmodule

//--- design/fds_disk.sv
// fds disk pointer: byte position on the current side, end detection and image offset
`timescale 1ns/1ps

module fds_disk import fds_pkg::*; (
	input  logic       clk20,
	input  logic       reset,
	input  logic       ce,
	input  ctrl_regs_t regs,
	input  seq_t       seq,
	input  logic [1:0] side_manual,
	output disk_info_t disk
);

	logic [15:0] pos;
	logic [1:0]  side;
	logic [17:0] side_offset;

	// end of side, pointer stops here
	assign disk.disk_end = (pos == 16'(SIDE_LEN - 1));

	// one byte per completed read sequence
	always_ff @(posedge clk20) begin
		if (reset)
			pos <= 16'd0;
		else if (ce) begin
			if (regs.disk_reset)
				pos <= 16'd0;
			else if (seq.read_active && !disk.disk_end)
				pos <= pos + 16'd1;
		end
	end

	// bios side plus user side, wraps at four sides
	assign side = regs.side_auto + side_manual;

	// skip header then whole sides
	always_comb begin
		side_offset = 18'(SIDE_BASE + SIDE_LEN * side);
	end

	assign disk.rom_offset = 18'(pos) + side_offset;

endmodule

//--- design/fds_addr_map.sv
// fds address map: prg bank select and access permission, chr-ram and nametable mirroring
`timescale 1ns/1ps

module fds_addr_map import fds_pkg::*; #(
	parameter int PRG_W = PRG_ADDR_W,
	parameter int CHR_W = CHR_ADDR_W
) (
	input  cpu_bus_t         cpu,
	input  ctrl_regs_t       regs,
	input  seq_t             seq,
	input  disk_info_t       disk,
	input  logic [13:0]      chr_ain,
	input  logic             chr_wr,
	output logic [PRG_W-1:0] prg_aout,
	output logic             prg_allow,
	output logic [CHR_W-1:0] chr_aout,
	output logic             chr_ram_we,
	output logic             vram_ce,
	output logic             vram_a10
);

	logic [5:0] prg_bank;
	logic       busy;
	logic       port_hit;
	logic       wr_ok;
	logic       rd_ok;

	assign busy = seq.read_active | seq.write_active;

	// e000-ffff bios, or disk image during a transfer
	// 6000-dfff work ram in banks 4-7
	always_comb begin
		if (cpu.addr[15:13] == 3'b111)
			prg_bank = busy ? {1'b1, disk.rom_offset[17:13]} : 6'd0;
		else
			prg_bank = {4'b0001, cpu.addr[14:13]};
	end

	assign prg_aout = {{(PRG_W - 19){1'b0}}, prg_bank, cpu.addr[12:0]};

	// offset readback comes from the mapper, keep memory off the bus
	assign port_hit = ~busy & (is_offset_lo(cpu.addr, regs.write_en) |
		is_offset_hi(cpu.addr, regs.write_en));

	// writes to work ram or the disk byte of a write sequence
	assign wr_ok = cpu.wr & (seq.write_active | (cpu.addr[15] ^ (&cpu.addr[14:13])));
	// reads anywhere in 6000-ffff
	assign rd_ok = cpu.rd & ((cpu.addr[15] & ~port_hit) | (cpu.addr[15:13] == 3'b011));
	assign prg_allow = wr_ok | rd_ok;

	// pattern tables in chr-ram, 2000-3fff to internal vram
	assign chr_ram_we = chr_wr & ~chr_ain[13];
	assign vram_ce    = chr_ain[13];

	// nametables use a10 for vertical, a11 for horizontal
	always_comb begin
		if (chr_ain[13])
			vram_a10 = regs.vertical ? chr_ain[10] : chr_ain[11];
		else
			vram_a10 = chr_ain[10];
	end

	assign chr_aout = {CHR_RAM_BASE, {(CHR_W - 16){1'b0}}, chr_ain[12:11], vram_a10,
		chr_ain[9:0]};

endmodule

//--- design/fds_read_mux.sv
// fds read mux: picks cpu read data from status registers, disk offset or external memory
`timescale 1ns/1ps

module fds_read_mux import fds_pkg::*; (
	input  cpu_bus_t   cpu,
	input  ctrl_regs_t regs,
	input  seq_t       seq,
	input  disk_info_t disk,
	input  logic       irq,
	input  logic       saved,
	input  logic       fds_swap,
	input  logic [7:0] ram_dout,
	output logic [7:0] prg_dout
);

	logic busy;
	logic eject;
	logic lo_hit;
	logic hi_hit;

	// eject follows the swap input only
	assign eject = fds_swap;

	// during a transfer these addresses read the image byte from memory
	assign busy   = seq.read_active | seq.write_active;
	assign lo_hit = ~busy & is_offset_lo(cpu.addr, regs.write_en);
	assign hi_hit = ~busy & is_offset_hi(cpu.addr, regs.write_en);

	always_comb begin
		prg_dout = ram_dout;
		if (lo_hit) begin
			prg_dout = disk.rom_offset[7:0];
		end else if (hi_hit) begin
			// 111 on top, as the bios expects
			prg_dout = {3'b111, disk.rom_offset[12:8]};
		end else begin
			case (cpu.addr)
				REG_IRQ_STATUS:
					prg_dout = {7'd0, irq};
				// eject in bits 0 and 2
				REG_DRIVE_STATUS:
					prg_dout = {5'd0, eject, disk.disk_end, eject};
				// battery good
				REG_POWER_STATUS:
					prg_dout = 8'h80;
				REG_SAVE_FLAG:
					prg_dout = {7'd0, saved};
				default:
					prg_dout = ram_dout;
			endcase
		end
	end

endmodule

//--- design/fds_mapper.sv
// fds mapper top: joins register control, timer, disk pointer, address map and read mux
`timescale 1ns/1ps

module fds_mapper import fds_pkg::*; #(
	parameter int PRG_W = PRG_ADDR_W,
	parameter int CHR_W = CHR_ADDR_W
) (
	input  logic             clk20,
	input  logic             reset,
	input  logic             ce,
	input  cpu_bus_t         cpu,
	input  logic [7:0]       ram_dout,
	input  logic [13:0]      chr_ain,
	input  logic             chr_wr,
	input  logic [1:0]       side_manual,
	input  logic             fds_swap,
	output logic [7:0]       prg_dout,
	output logic [PRG_W-1:0] prg_aout,
	output logic             prg_allow,
	output logic [CHR_W-1:0] chr_aout,
	output logic             chr_ram_we,
	output logic             vram_ce,
	output logic             vram_a10,
	output logic             irq
);

	ctrl_regs_t regs;
	seq_t       seq;
	disk_info_t disk;
	logic       saved;

	// register file, sequence detectors, save flag
	fds_ctrl ctrl_i (
		.clk20 (clk20),
		.reset (reset),
		.ce    (ce),
		.cpu   (cpu),
		.regs  (regs),
		.seq   (seq),
		.saved (saved)
	);

	fds_timer timer_i (
		.clk20 (clk20),
		.reset (reset),
		.ce    (ce),
		.cpu   (cpu),
		.regs  (regs),
		.irq   (irq)
	);

	fds_disk disk_i (
		.clk20       (clk20),
		.reset       (reset),
		.ce          (ce),
		.regs        (regs),
		.seq         (seq),
		.side_manual (side_manual),
		.disk        (disk)
	);

	// widths handed down from here
	fds_addr_map #(
		.PRG_W (PRG_W),
		.CHR_W (CHR_W)
	) addr_map_i (
		.cpu        (cpu),
		.regs       (regs),
		.seq        (seq),
		.disk       (disk),
		.chr_ain    (chr_ain),
		.chr_wr     (chr_wr),
		.prg_aout   (prg_aout),
		.prg_allow  (prg_allow),
		.chr_aout   (chr_aout),
		.chr_ram_we (chr_ram_we),
		.vram_ce    (vram_ce),
		.vram_a10   (vram_a10)
	);

	fds_read_mux read_mux_i (
		.cpu      (cpu),
		.regs     (regs),
		.seq      (seq),
		.disk     (disk),
		.irq      (irq),
		.saved    (saved),
		.fds_swap (fds_swap),
		.ram_dout (ram_dout),
		.prg_dout (prg_dout)
	);

endmodule

//--- bench/fds_checker.sv
// fds mapper checker: samples mapper outputs on ce cycles and compares them with expected values
`timescale 1ns/1ps

module fds_checker import fds_pkg::*; #(
	parameter int PRG_W = PRG_ADDR_W,
	parameter int CHR_W = CHR_ADDR_W
) (
	input  logic             clk20,
	input  logic             reset,
	input  logic             ce,
	input  cpu_bus_t         cpu,
	input  logic [13:0]      chr_ain,
	input  logic             chr_wr,
	input  logic [7:0]       prg_dout,
	input  logic             irq,
	input  logic [PRG_W-1:0] prg_aout,
	input  logic             prg_allow,
	input  logic [CHR_W-1:0] chr_aout,
	input  logic             chr_ram_we,
	input  logic             vram_ce,
	input  logic             vram_a10,
	input  logic             check_en,
	input  logic [127:0]     check_name,
	input  logic [63:0]      check_kind,
	input  logic [31:0]      check_exp,
	input  logic             report_req,
	output logic             report_done,
	output int               tests_run,
	output int               tests_failed,
	output int               values_wrong
);

	logic [127:0] cur_name;
	int           cur_checks;
	int           cur_wrong;
	// ce strobes since the last timer control write
	int           since_ctrl;
	// strobe count at which irq last came up
	int           rise_count;
	logic         irq_last;

	// one summary line per finished test
	task automatic close_test();
		if (cur_name != '0) begin
			tests_run++;
			if (cur_wrong == 0) begin
				$display("PASS %0s, %0d checks", cur_name, cur_checks);
			end else begin
				tests_failed++;
				$display("FAIL %0s, %0d of %0d checks wrong", cur_name, cur_wrong, cur_checks);
			end
		end
		cur_checks = 0;
		cur_wrong  = 0;
	endtask

	// one comparison against an expected value
	task automatic score_value(input logic [63:0] kind, input logic [31:0] exp,
		input logic [31:0] act);
		cur_checks++;
		if (act !== exp) begin
			$display("ERR %0s %0s expected %0h actual %0h", cur_name, kind, exp, act);
			cur_wrong++;
			values_wrong++;
		end
	endtask

	task automatic compare_value();
		logic [31:0] act;
		logic        known;
		act   = '0;
		known = 1'b1;
		case (check_kind)
			"dout":  act = 32'(prg_dout);
			"irq":   act = 32'(irq);
			"aout":  act = 32'(prg_aout);
			"allow": act = 32'(prg_allow);
			"a10":   act = 32'(vram_a10);
			"cnt":   act = 32'(rise_count);
			default: known = 1'b0;
		endcase
		if (!known) begin
			cur_checks++;
			$display("test %0s asks for an unknown check %0s", cur_name, check_kind);
			cur_wrong++;
		end else begin
			score_value(check_kind, check_exp, act);
		end
	endtask

	// ppu side, 0000-1fff is chr-ram, 2000-3fff console vram
	task automatic check_chr_side();
		logic             nametable;
		logic [CHR_W-1:0] exp_aout;
		nametable = (chr_ain >= 14'h2000);
		exp_aout  = {CHR_RAM_BASE, {(CHR_W - 3){1'b0}}} | {{(CHR_W - 14){1'b0}}, chr_ain};
		score_value("vce", 32'(nametable), 32'(vram_ce));
		score_value("cwe", 32'(chr_wr && !nametable), 32'(chr_ram_we));
		// pattern fetches land in chr-ram unchanged
		if (!nametable)
			score_value("caout", 32'(exp_aout), 32'(chr_aout));
	endtask

	// outputs are sampled before this edge updates any state
	always @(posedge clk20) begin
		if (reset) begin
			report_done  = 1'b0;
			tests_run    = 0;
			tests_failed = 0;
			values_wrong = 0;
			cur_name     = '0;
			cur_checks   = 0;
			cur_wrong    = 0;
			since_ctrl   = 0;
			rise_count   = 0;
			irq_last     = 1'b0;
		end else begin
			if (ce && cpu.wr && cpu.addr == REG_TIMER_CTRL)
				since_ctrl = 0;
			else if (ce)
				since_ctrl++;
			// irq came up on an earlier edge, count still holds that strobe
			if (irq && !irq_last)
				rise_count = since_ctrl;
			irq_last = irq;
			if (ce && check_en) begin
				// new name starts a new test
				if (check_name != cur_name) begin
					close_test();
					cur_name = check_name;
				end
				if (check_kind != "none")
					compare_value();
				check_chr_side();
			end
			if (report_req && !report_done) begin
				close_test();
				cur_name    = '0;
				report_done = 1'b1;
			end
		end
	end

endmodule

//--- bench/fds_mapper_sva.sv
// fds mapper assertions: timer interrupt source and prg address range
`timescale 1ns/1ps

module fds_mapper_sva import fds_pkg::*; #(
	parameter int PRG_W = PRG_ADDR_W
) (
	input logic             clk20,
	input logic             reset,
	input logic             irq,
	input logic             timer_en,
	input logic [PRG_W-1:0] prg_aout
);

	// a trip needs the timer running on the edge that raised irq
	irq_needs_enable: assert property (@(posedge clk20) disable iff (reset)
		$rose(irq) |-> $past(timer_en))
		else $error("irq rose while the timer was disabled");

	// bios, disk image and work ram all fit below 512k
	prg_top_bits_zero: assert property (@(posedge clk20) disable iff (reset)
		prg_aout[PRG_W-1 -: 3] == 3'b000)
		else $error("prg address above the mapped range");

endmodule

bind fds_mapper fds_mapper_sva #(
	.PRG_W (PRG_W)
) sva_i (
	.clk20    (clk20),
	.reset    (reset),
	.irq      (irq),
	.timer_en (regs.timer_en),
	.prg_aout (prg_aout)
);

//--- bench/fds_mapper_tb.sv
// fds mapper testbench: replays bus cycles from the stimulus file and prints the summary
`timescale 1ns/1ps

module fds_mapper_tb import fds_pkg::*; ();

	localparam int PRG_W     = PRG_ADDR_W;
	localparam int CHR_W     = CHR_ADDR_W;
	localparam int IRQ_LIMIT = 64;
	localparam int MAX_LINES = 512;

	logic             clk20;
	logic             reset;
	logic             ce;
	cpu_bus_t         cpu;
	logic [7:0]       ram_dout;
	logic [13:0]      chr_ain;
	logic             chr_wr;
	logic [1:0]       side_manual;
	logic             fds_swap;
	logic [7:0]       prg_dout;
	logic [PRG_W-1:0] prg_aout;
	logic             prg_allow;
	logic [CHR_W-1:0] chr_aout;
	logic             chr_ram_we;
	logic             vram_ce;
	logic             vram_a10;
	logic             irq;

	// what the checker compares on the current ce cycle
	logic             check_en;
	logic [127:0]     check_name;
	logic [63:0]      check_kind;
	logic [31:0]      check_exp;
	logic             report_req;
	logic             report_done;
	int               tests_run;
	int               tests_failed;
	int               values_wrong;

	fds_mapper #(
		.PRG_W (PRG_W),
		.CHR_W (CHR_W)
	) fds_mapper_i (
		.clk20       (clk20),
		.reset       (reset),
		.ce          (ce),
		.cpu         (cpu),
		.ram_dout    (ram_dout),
		.chr_ain     (chr_ain),
		.chr_wr      (chr_wr),
		.side_manual (side_manual),
		.fds_swap    (fds_swap),
		.prg_dout    (prg_dout),
		.prg_aout    (prg_aout),
		.prg_allow   (prg_allow),
		.chr_aout    (chr_aout),
		.chr_ram_we  (chr_ram_we),
		.vram_ce     (vram_ce),
		.vram_a10    (vram_a10),
		.irq         (irq)
	);

	fds_checker #(
		.PRG_W (PRG_W),
		.CHR_W (CHR_W)
	) checker_i (
		.clk20        (clk20),
		.reset        (reset),
		.ce           (ce),
		.cpu          (cpu),
		.chr_ain      (chr_ain),
		.chr_wr       (chr_wr),
		.prg_dout     (prg_dout),
		.irq          (irq),
		.prg_aout     (prg_aout),
		.prg_allow    (prg_allow),
		.chr_aout     (chr_aout),
		.chr_ram_we   (chr_ram_we),
		.vram_ce      (vram_ce),
		.vram_a10     (vram_a10),
		.check_en     (check_en),
		.check_name   (check_name),
		.check_kind   (check_kind),
		.check_exp    (check_exp),
		.report_req   (report_req),
		.report_done  (report_done),
		.tests_run    (tests_run),
		.tests_failed (tests_failed),
		.values_wrong (values_wrong)
	);

	// 10 ns clock
	initial begin
		clk20 = 1'b0;
		forever #5 clk20 = ~clk20;
	end

	// one bus cycle, ce high for one clock out of four
	task automatic run_ce_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic rd, input logic wr, input logic [63:0] kind, input logic [31:0] exp);
		@(negedge clk20);
		cpu.addr   = addr;
		cpu.data   = data;
		cpu.rd     = rd;
		cpu.wr     = wr;
		ce         = 1'b1;
		check_en   = 1'b1;
		check_kind = kind;
		check_exp  = exp;
		@(negedge clk20);
		ce       = 1'b0;
		check_en = 1'b0;
		cpu.rd   = 1'b0;
		cpu.wr   = 1'b0;
		// address stays on the bus
		repeat (2) @(negedge clk20);
	endtask

	// idle strobes until irq shows up, bounded
	task automatic wait_for_irq(output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < IRQ_LIMIT) begin
			run_ce_cycle(16'h0000, 8'h00, 1'b0, 1'b0, "none", 32'd0);
			seen = irq;
			n++;
		end
	endtask

	initial begin
		int              fd;
		int              n;
		int              fields;
		int              line_no;
		int              problems;
		logic            seen;
		logic            timed_out;
		logic [8*96-1:0] line;
		logic [7:0]      first;
		logic [127:0]    name;
		logic [63:0]     op;
		logic [15:0]     addr;
		logic [7:0]      data;
		logic [63:0]     kind;
		logic [31:0]     exp;

		ce          = 1'b0;
		cpu         = '0;
		// open bus filler from external memory
		ram_dout    = 8'hea;
		chr_ain     = '0;
		chr_wr      = 1'b0;
		side_manual = 2'd0;
		fds_swap    = 1'b0;
		check_en    = 1'b0;
		check_name  = '0;
		check_kind  = "none";
		check_exp   = '0;
		report_req  = 1'b0;
		problems    = 0;
		timed_out   = 1'b0;
		line_no     = 0;
		reset       = 1'b1;
		repeat (8) @(negedge clk20);
		reset = 1'b0;

		fd = $fopen("bench/fds_stimulus.txt", "r");
		if (fd == 0) begin
			$display("stimulus file bench/fds_stimulus.txt could not be opened");
			problems++;
		end else begin
			while (!timed_out && line_no < MAX_LINES && !$feof(fd)) begin
				line = '0;
				n = $fgets(line, fd);
				line_no++;
				if (n > 1 && n <= 96) begin
					// first character sits in the highest filled byte
					first = line[8*n-1 -: 8];
					if (first != "#") begin
						fields = $sscanf(line, "%s %s %h %h %s %h", name, op, addr, data,
							kind, exp);
						if (fields != 6) begin
							$display("line %0d of the stimulus file is malformed", line_no);
							problems++;
						end else begin
							check_name = name;
							case (op)
								"wr":
									run_ce_cycle(addr, data, 1'b0, 1'b1, kind, exp);
								"rd":
									run_ce_cycle(addr, data, 1'b1, 1'b0, kind, exp);
								"idle":
									run_ce_cycle(addr, data, 1'b0, 1'b0, kind, exp);
								"chr": begin
									// ppu address only, no cpu access
									chr_ain = addr[13:0];
									run_ce_cycle(16'h0000, 8'h00, 1'b0, 1'b0, kind, exp);
								end
								"swap": begin
									fds_swap = data[0];
									run_ce_cycle(16'h0000, 8'h00, 1'b0, 1'b0, kind, exp);
								end
								"irq": begin
									wait_for_irq(seen);
									if (!seen) begin
										$display("irq did not rise within %0d ce strobes in test %0s",
											IRQ_LIMIT, name);
										timed_out = 1'b1;
									end else begin
										run_ce_cycle(16'h0000, 8'h00, 1'b0, 1'b0, kind, exp);
									end
								end
								default: begin
									$display("line %0d names an unknown operation %0s", line_no, op);
									problems++;
								end
							endcase
						end
					end
				end
			end
			$fclose(fd);
		end

		// let the checker close the last test
		@(negedge clk20);
		report_req = 1'b1;
		n = 0;
		while (!report_done && n < 16) begin
			@(negedge clk20);
			n++;
		end
		if (!report_done) begin
			$display("checker did not finish its report");
			problems++;
		end
		if (timed_out)
			problems++;
		$display("%0d tests run, %0d failed, %0d wrong values, %0d other problems",
			tests_run, tests_failed, values_wrong, problems);
		if (tests_run > 0 && tests_failed == 0 && values_wrong == 0 && problems == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- verilog.f
design/fds_pkg.sv
design/fds_ctrl.sv
design/fds_timer.sv
design/fds_disk.sv
design/fds_addr_map.sv
design/fds_read_mux.sv
design/fds_mapper.sv
bench/fds_checker.sv
bench/fds_mapper_sva.sv
bench/fds_mapper_tb.sv

//--- bench/fds_stimulus.txt
# columns: test op addr(hex) data(hex) check expected(hex)
# ops wr rd idle chr swap irq, checks dout irq aout allow a10 cnt none
timer wr 4020 05 none 0
timer wr 4021 00 none 0
timer wr 4022 02 irq 0
timer irq 0000 00 cnt 5
timer rd 4030 00 dout 1
timer rd 4030 00 irq 0
disk_offset wr 4027 02 none 0
disk_offset wr 4025 06 none 0
disk_offset wr 4025 04 none 0
disk_offset rd f4d1 00 dout ff
disk_offset rd f4d0 00 dout c8
disk_advance rd f4d0 00 allow 0
disk_advance rd f4d1 00 dout ff
disk_advance rd e005 00 aout 5e005
disk_advance rd f4d0 00 dout c9
disk_advance rd e005 00 aout 5
prg_map rd 6123 00 aout e123
prg_map rd 8abc 00 aout 8abc
prg_map rd c000 00 aout c000
prg_map rd 6000 00 allow 1
prg_map rd 6000 00 dout ea
save_flag rd 4208 00 dout 0
save_flag wr 4025 00 none 0
save_flag rd f4cd 00 none 0
save_flag rd f4ce 00 none 0
save_flag rd e000 00 aout 5e000
save_flag rd 4208 00 dout 1
mirroring wr 4025 04 none 0
mirroring chr 2400 00 a10 1
mirroring chr 2800 00 a10 0
mirroring wr 4025 0c none 0
mirroring chr 2400 00 a10 0
mirroring chr 2800 00 a10 1
drive_status swap 0000 01 none 0
drive_status rd 4032 00 dout 5
drive_status rd 4033 00 dout 80
drive_status swap 0000 00 none 0
drive_status rd 4032 00 dout 0
